//--- Bender.yml
package:
  name: tl45_exec

sources:
  - hw/tl45_pkg.sv
  - hw/tl45_regfile.sv
  - hw/tl45_branch_unit.sv
  - hw/tl45_alu.sv
  - hw/tl45_exec_top.sv
  - target: test
    files:
      - dv/tb_clkgen.sv
      - dv/tb_exec_assert.sv
      - dv/tb_checker.sv
      - dv/tb_top.sv

//--- dv/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_in_valid,
    input  logic                        i_in_ready,
    input  tl45_pkg::opcode_e           i_opcode,
    input  logic [tl45_pkg::REG_W-1:0]  i_dr,
    input  logic [tl45_pkg::REG_W-1:0]  i_sr1,
    input  logic [tl45_pkg::REG_W-1:0]  i_sr2,
    input  tl45_pkg::cond_e             i_jmp_cond,
    input  logic [tl45_pkg::DATA_W-1:0] i_target_offset,
    input  logic                        i_wb_valid,
    input  logic [tl45_pkg::REG_W-1:0]  i_wb_reg,
    input  logic [tl45_pkg::DATA_W-1:0] i_wb_val,
    input  logic                        i_redirect_valid,
    input  logic [tl45_pkg::DATA_W-1:0] i_redirect_pc,
    output int                          o_value_errors,
    output int                          o_output_errors,
    output int                          o_accepted
);
    import tl45_pkg::*;

    logic [DATA_W-1:0] regs [1 << REG_W];
    logic              f_v;  // Model flags
    logic              f_z;
    logic              f_c;
    logic              f_n;
    logic              exp_wb;
    logic              exp_rd;
    logic [REG_W-1:0]  exp_reg;
    logic [DATA_W-1:0] exp_val;
    logic [DATA_W-1:0] exp_pc;
    int                stalls;

    // Codes pair up, odd code is the inverse of the even one
    function automatic logic cond_holds(input logic [3:0] cond);
        logic base;
        case (cond[3:1])
            3'd0:    base = f_v;
            3'd1:    base = f_n;
            3'd2:    base = f_z;
            3'd3:    base = f_c;
            3'd4:    base = f_c | f_z;
            3'd5:    base = f_n ^ f_v;
            3'd6:    base = f_z | (f_n ^ f_v);
            default: return 1'b1;  // 14 and 15 always jump
        endcase
        return base ^ cond[0];
    endfunction

    task automatic reset_model();
        for (int i = 0; i < (1 << REG_W); i++) begin
            regs[i] = '0;
        end
        {f_v, f_z, f_c, f_n} = 4'b0;
        {exp_wb, exp_rd} = 2'b0;
        stalls = 0;
        o_value_errors = 0;
        o_output_errors = 0;
        o_accepted = 0;
    endtask

    task automatic compare_outputs();
        if (exp_wb != i_wb_valid) begin
            $display("%s writeback at time %0t", exp_wb ? "Missing" : "Unexpected", $time);
            o_output_errors++;
        end else if (exp_wb && (i_wb_reg != exp_reg || i_wb_val != exp_val)) begin
            $display("FAIL %0t: writeback r%0d=%h, expected r%0d=%h",
                     $time, i_wb_reg, i_wb_val, exp_reg, exp_val);
            o_value_errors++;
        end
        if (exp_rd != i_redirect_valid) begin
            $display("%s redirect at time %0t", exp_rd ? "Missing" : "Unexpected", $time);
            o_output_errors++;
        end else if (exp_rd && i_redirect_pc != exp_pc) begin
            $display("FAIL %0t: redirect pc %h, expected %h", $time, i_redirect_pc, exp_pc);
            o_value_errors++;
        end
    endtask

    task automatic predict();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] b_eff;
        logic [DATA_W-1:0] res;
        logic [DATA_W:0]   wide;  // 33-bit sum, carry or borrow on top
        logic              sub;
        logic              arith;
        a     = regs[i_sr1];
        b     = regs[i_sr2];
        sub   = (i_opcode == OP_SUB);
        arith = (i_opcode inside {OP_ADD, OP_SUB});
        wide  = sub ? ({1'b0, a} - {1'b0, b}) : ({1'b0, a} + {1'b0, b});
        case (i_opcode)
            OP_ADD, OP_SUB: res = wide[DATA_W-1:0];
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_NOT:  res = ~a;
            OP_MUL:  res = a * b;
            OP_SHL:  res = (b < DATA_W) ? (a << b) : '0;
            OP_SHR:  res = (b < DATA_W) ? (a >> b) : '0;
            OP_SHRA: res = $signed(a) >>> ((b < DATA_W) ? b : DATA_W - 1);
            OP_CALL: res = b - 4;
            OP_RET:  res = b + 4;
            default: res = '0;
        endcase
        if (stalls != ((i_opcode == OP_MUL) ? 1 : 0)) begin
            $display("FAIL %0t: %0d stall cycles before opcode %0d", $time, stalls, i_opcode);
            o_value_errors++;
        end
        stalls = 0;
        o_accepted++;
        exp_wb  = (i_opcode inside {OP_ADD, OP_SUB, OP_MUL, OP_SHRA, OP_OR, OP_XOR,
                                    OP_AND, OP_NOT, OP_SHL, OP_SHR, OP_CALL, OP_RET});
        exp_reg = i_dr;
        exp_val = res;
        exp_rd  = (i_opcode == OP_BR) && cond_holds(i_jmp_cond);  // Flags before update
        exp_pc  = a + i_target_offset;
        if (exp_wb && i_dr != '0) begin
            regs[i_dr] = res;
        end
        if (i_opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT}) begin
            f_z = (res == '0);
            f_n = res[DATA_W-1];
            f_c = arith & wide[DATA_W];
            // Effective b is negated for SUB
            b_eff = sub ? -b : b;
            f_v = arith && (a[DATA_W-1] == b_eff[DATA_W-1])
                  && (res[DATA_W-1] != a[DATA_W-1]);
        end
    endtask

    always @(posedge i_clk) begin
        if (i_reset) begin
            reset_model();
        end else begin
            compare_outputs();
            if (i_in_valid && !i_in_ready) begin
                stalls++;
            end
            if (i_in_valid && i_in_ready) begin
                predict();
            end else begin
                exp_wb = 1'b0;
                exp_rd = 1'b0;
            end
        end
    end

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 10
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;  // Half period per phase
        end
    end

endmodule

//--- dv/tb_exec_assert.sv
`timescale 1ns/1ps

module tb_exec_assert (
    input logic                        i_clk,
    input logic                        i_reset,
    input logic                        i_in_valid,
    input logic                        i_in_ready,
    input tl45_pkg::opcode_e           i_opcode,
    input logic [tl45_pkg::REG_W-1:0]  i_dr,
    input logic [tl45_pkg::REG_W-1:0]  i_sr1,
    input logic [tl45_pkg::REG_W-1:0]  i_sr2,
    input tl45_pkg::cond_e             i_jmp_cond,
    input logic [tl45_pkg::DATA_W-1:0] i_target_offset,
    input logic                        i_wb_valid,
    input logic                        i_redirect_valid
);
    import tl45_pkg::*;

    int error_count = 0;  // Read by the testbench top

    // A branch never writes back, so both outputs are exclusive
    a_one_output: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wb_valid && i_redirect_valid))
        else begin
            error_count++;
            $error("Writeback and redirect valid in the same cycle");
        end

    a_stable_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_in_valid && !i_in_ready) |=> (i_in_valid && $stable(i_opcode) && $stable(i_dr)
            && $stable(i_sr1) && $stable(i_sr2) && $stable(i_jmp_cond)
            && $stable(i_target_offset)))
        else begin
            error_count++;
            $error("Input fields changed during a stall");
        end

    a_stall_is_mul: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_in_valid && !i_in_ready) |-> (i_opcode == OP_MUL))
        else begin
            error_count++;
            $error("Stall seen on an instruction other than MUL");
        end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import tl45_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_REGS        = 16;
    localparam int NUM_PRELOAD     = 15;
    localparam int NUM_RANDOM      = 2000;
    localparam int WATCHDOG_CYCLES = 3 * (NUM_PRELOAD + NUM_RANDOM) + 20;

    logic              clk;
    logic              reset;
    logic              in_valid;
    opcode_e           opcode;
    logic [REG_W-1:0]  dr;
    logic [REG_W-1:0]  sr1;
    logic [REG_W-1:0]  sr2;
    cond_e             jmp_cond;
    logic [DATA_W-1:0] target_offset;
    logic              in_ready;
    logic              wb_valid;
    logic [REG_W-1:0]  wb_reg;
    logic [DATA_W-1:0] wb_val;
    logic              redirect_valid;
    logic [DATA_W-1:0] redirect_pc;
    int                value_errors;
    int                output_errors;
    int                accepted;
    int                assert_errors;
    int                seed_unused;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD)) i_clkgen (.o_clk(clk));

    tl45_exec_top #(
        .NUM_REGS (NUM_REGS)
    ) i_dut (
        .i_clk (clk), .i_reset (reset), .i_in_valid (in_valid), .i_opcode (opcode),
        .i_dr (dr), .i_sr1 (sr1), .i_sr2 (sr2), .i_jmp_cond (jmp_cond),
        .i_target_offset (target_offset), .o_in_ready (in_ready), .o_wb_valid (wb_valid),
        .o_wb_reg (wb_reg), .o_wb_val (wb_val), .o_redirect_valid (redirect_valid),
        .o_redirect_pc (redirect_pc)
    );

    tb_checker i_checker (
        .i_clk (clk), .i_reset (reset), .i_in_valid (in_valid), .i_in_ready (in_ready),
        .i_opcode (opcode), .i_dr (dr), .i_sr1 (sr1), .i_sr2 (sr2), .i_jmp_cond (jmp_cond),
        .i_target_offset (target_offset), .i_wb_valid (wb_valid), .i_wb_reg (wb_reg),
        .i_wb_val (wb_val), .i_redirect_valid (redirect_valid), .i_redirect_pc (redirect_pc),
        .o_value_errors (value_errors), .o_output_errors (output_errors),
        .o_accepted (accepted)
    );

    bind tl45_exec_top tb_exec_assert i_exec_assert (
        .i_clk (i_clk), .i_reset (i_reset), .i_in_valid (i_in_valid),
        .i_in_ready (o_in_ready), .i_opcode (i_opcode), .i_dr (i_dr), .i_sr1 (i_sr1),
        .i_sr2 (i_sr2), .i_jmp_cond (i_jmp_cond), .i_target_offset (i_target_offset),
        .i_wb_valid (o_wb_valid), .i_redirect_valid (o_redirect_valid)
    );

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(
        input opcode_e           op,
        input logic [REG_W-1:0]  d,
        input logic [REG_W-1:0]  s1,
        input logic [REG_W-1:0]  s2,
        input cond_e             cond,
        input logic [DATA_W-1:0] off
    );
        in_valid      = 1'b1;
        opcode        = op;
        dr            = d;
        sr1           = s1;
        sr2           = s2;
        jmp_cond      = cond;
        target_offset = off;
        do @(posedge clk); while (!in_ready);
        @(negedge clk);
    endtask

    function automatic opcode_e pick_opcode();
        logic [4:0] raw;
        raw = 5'($urandom_range(15));
        if ($urandom_range(19) == 0) begin
            raw = 5'($urandom_range(31, 15));  // Unused codes act as NOP
        end
        return opcode_e'(raw);
    endfunction

    initial begin
        seed_unused = $urandom(88790);
        reset = 1'b1;
        in_valid = 1'b0;
        opcode = OP_NOP;
        {dr, sr1, sr2} = '0;
        jmp_cond = JO;
        target_offset = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Seed registers from r0, dependent chain exercises the bypass
        issue(OP_RET, 4'd1, 4'd0, 4'd0, JO, '0);
        issue(OP_RET, 4'd2, 4'd0, 4'd1, JO, '0);
        issue(OP_CALL, 4'd3, 4'd0, 4'd0, JO, '0);
        for (int i = 4; i < NUM_REGS; i++) begin
            issue(OP_ADD, REG_W'(i), REG_W'(i - 1), REG_W'(i - 2), JO, '0);
        end
        for (int k = 0; k < NUM_RANDOM; k++) begin
            if ($urandom_range(3) == 0) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            issue(pick_opcode(), REG_W'($urandom), REG_W'($urandom), REG_W'($urandom),
                  cond_e'(4'($urandom)), $urandom);
        end
        in_valid = 1'b0;
        repeat (3) @(negedge clk);
        assert_errors = i_dut.i_exec_assert.error_count;
        $display("Done: %0d accepted, %0d value errors, %0d missing or extra, %0d assertion",
                 accepted, value_errors, output_errors, assert_errors);
        if (value_errors + output_errors + assert_errors == 0
                && accepted == NUM_PRELOAD + NUM_RANDOM) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- hw/tl45_alu.sv
`timescale 1ns/1ps

module tl45_alu (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  tl45_pkg::opcode_e           i_opcode,
    input  logic [tl45_pkg::REG_W-1:0]  i_dr,
    input  logic [tl45_pkg::DATA_W-1:0] i_sr1_val,
    input  logic [tl45_pkg::DATA_W-1:0] i_sr2_val,
    input  logic [tl45_pkg::DATA_W-1:0] i_target_offset,
    output logic                        o_ready,
    output logic                        o_flag_we,
    output tl45_pkg::flags_t            o_next_flags,
    input  logic                        i_taken,
    output logic                        o_wb_valid,
    output logic [tl45_pkg::REG_W-1:0]  o_wb_reg,
    output logic [tl45_pkg::DATA_W-1:0] o_wb_val,
    output logic                        o_redirect_valid,
    output logic [tl45_pkg::DATA_W-1:0] o_redirect_pc
);
    import tl45_pkg::*;

    localparam int SH_W = $clog2(DATA_W);

    logic [DATA_W:0]          b_eff;       // Operand b, negated for SUB
    logic [DATA_W:0]          sum;         // Carry in the top bit
    logic [DATA_W-1:0]        result;
    logic [SH_W-1:0]          shamt;
    logic                     shamt_big;   // Shift out of range
    logic signed [DATA_W-1:0] sra_val;
    logic                     arith;
    logic                     set_flags;
    logic                     writes_back;
    logic                     is_branch;
    logic                     mul_start;   // MUL seen for the first time
    logic                     accept;
    mul_state_e               mul_state;
    logic [DATA_W-1:0]        mul_prod;

    always_comb begin
        arith       = 1'b0;
        set_flags   = 1'b0;
        writes_back = 1'b0;
        case (i_opcode)
            OP_ADD, OP_SUB: begin
                arith       = 1'b1;
                set_flags   = 1'b1;
                writes_back = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR, OP_NOT: begin
                set_flags   = 1'b1;
                writes_back = 1'b1;
            end
            OP_MUL, OP_SHL, OP_SHR, OP_SHRA, OP_CALL, OP_RET: begin
                writes_back = 1'b1;
            end
            default: writes_back = 1'b0;  // NOP, BR and unused codes
        endcase
    end

    assign is_branch = (i_opcode == OP_BR);

    assign b_eff = (i_opcode == OP_SUB) ? (~{1'b0, i_sr2_val} + 1'b1) : {1'b0, i_sr2_val};
    assign sum   = {1'b0, i_sr1_val} + b_eff;

    assign shamt     = i_sr2_val[SH_W-1:0];
    assign shamt_big = (i_sr2_val[DATA_W-1:SH_W] != '0);
    assign sra_val   = $signed(i_sr1_val) >>> shamt;

    always_comb begin
        case (i_opcode)
            OP_ADD, OP_SUB: result = sum[DATA_W-1:0];
            OP_AND:  result = i_sr1_val & i_sr2_val;
            OP_OR:   result = i_sr1_val | i_sr2_val;
            OP_XOR:  result = i_sr1_val ^ i_sr2_val;
            OP_NOT:  result = ~i_sr1_val;
            OP_RET:  result = i_sr2_val + DATA_W'(4);  // Pop
            OP_CALL: result = i_sr2_val - DATA_W'(4);  // Push
            OP_SHL:  result = shamt_big ? '0 : (i_sr1_val << shamt);
            OP_SHR:  result = shamt_big ? '0 : (i_sr1_val >> shamt);
            OP_SHRA: result = shamt_big ? {DATA_W{i_sr1_val[DATA_W-1]}} : sra_val;
            OP_MUL:  result = mul_prod;
            default: result = i_sr1_val;
        endcase
    end

    // Carry and overflow only mean something for ADD and SUB
    assign o_next_flags.zero     = (result == '0);
    assign o_next_flags.sign     = result[DATA_W-1];
    assign o_next_flags.carry    = arith & sum[DATA_W];
    assign o_next_flags.overflow = arith &
                                   (i_sr1_val[DATA_W-1] == b_eff[DATA_W-1]) &
                                   (result[DATA_W-1] != i_sr1_val[DATA_W-1]);

    // First cycle of a MUL is the only stall
    assign mul_start = i_valid && (i_opcode == OP_MUL) && (mul_state == MUL_IDLE);
    assign o_ready   = !mul_start;
    assign accept    = i_valid && o_ready;
    assign o_flag_we = accept && set_flags;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mul_state        <= MUL_IDLE;
            o_wb_valid       <= 1'b0;
            o_redirect_valid <= 1'b0;
        end else begin
            mul_state        <= mul_start ? MUL_WAIT : MUL_IDLE;
            o_wb_valid       <= accept && writes_back;
            o_redirect_valid <= accept && is_branch && i_taken;
        end
    end

    always_ff @(posedge i_clk) begin
        if (mul_start) begin
            mul_prod <= i_sr1_val * i_sr2_val;  // Low word of the product
        end
        if (accept) begin
            o_wb_reg      <= i_dr;
            o_wb_val      <= result;
            o_redirect_pc <= i_sr1_val + i_target_offset;
        end
    end

endmodule

//--- hw/tl45_branch_unit.sv
`timescale 1ns/1ps

module tl45_branch_unit (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_flag_we,
    input  tl45_pkg::flags_t i_next_flags,
    input  tl45_pkg::cond_e  i_jmp_cond,
    output logic             o_taken
);
    import tl45_pkg::*;

    flags_t flags;
    logic   below_eq;  // Unsigned less or equal
    logic   less;      // Signed less than

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            flags <= '0;
        end else if (i_flag_we) begin
            flags <= i_next_flags;
        end
    end

    assign below_eq = flags.carry | flags.zero;
    assign less     = flags.sign ^ flags.overflow;

    // Evaluated on the stored flags only
    always_comb begin
        case (i_jmp_cond)
            JO:      o_taken = flags.overflow;
            JNO:     o_taken = !flags.overflow;
            JS:      o_taken = flags.sign;
            JNS:     o_taken = !flags.sign;
            JE:      o_taken = flags.zero;
            JNE:     o_taken = !flags.zero;
            JB:      o_taken = flags.carry;
            JNB:     o_taken = !flags.carry;
            JBE:     o_taken = below_eq;
            JA:      o_taken = !below_eq;
            JL:      o_taken = less;
            JGE:     o_taken = !less;
            JLE:     o_taken = flags.zero | less;
            JG:      o_taken = !(flags.zero | less);
            default: o_taken = 1'b1;  // JMP
        endcase
    end

endmodule

//--- hw/tl45_exec_top.sv
`timescale 1ns/1ps

module tl45_exec_top #(
    parameter int NUM_REGS = 16
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_in_valid,
    input  tl45_pkg::opcode_e           i_opcode,
    input  logic [tl45_pkg::REG_W-1:0]  i_dr,
    input  logic [tl45_pkg::REG_W-1:0]  i_sr1,
    input  logic [tl45_pkg::REG_W-1:0]  i_sr2,
    input  tl45_pkg::cond_e             i_jmp_cond,
    input  logic [tl45_pkg::DATA_W-1:0] i_target_offset,
    output logic                        o_in_ready,
    output logic                        o_wb_valid,
    output logic [tl45_pkg::REG_W-1:0]  o_wb_reg,
    output logic [tl45_pkg::DATA_W-1:0] o_wb_val,
    output logic                        o_redirect_valid,
    output logic [tl45_pkg::DATA_W-1:0] o_redirect_pc
);
    import tl45_pkg::*;

    logic [DATA_W-1:0] sr1_val;
    logic [DATA_W-1:0] sr2_val;
    logic              flag_we;
    flags_t            next_flags;
    logic              taken;

    // Writeback feeds the register file and its bypass
    tl45_regfile #(
        .NUM_REGS (NUM_REGS)
    ) i_regfile (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rd_a     (i_sr1),
        .i_rd_b     (i_sr2),
        .o_rd_a_val (sr1_val),
        .o_rd_b_val (sr2_val),
        .i_wr_en    (o_wb_valid),
        .i_wr_reg   (o_wb_reg),
        .i_wr_val   (o_wb_val)
    );

    tl45_alu i_alu (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_valid          (i_in_valid),
        .i_opcode         (i_opcode),
        .i_dr             (i_dr),
        .i_sr1_val        (sr1_val),
        .i_sr2_val        (sr2_val),
        .i_target_offset  (i_target_offset),
        .o_ready          (o_in_ready),
        .o_flag_we        (flag_we),
        .o_next_flags     (next_flags),
        .i_taken          (taken),
        .o_wb_valid       (o_wb_valid),
        .o_wb_reg         (o_wb_reg),
        .o_wb_val         (o_wb_val),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc)
    );

    tl45_branch_unit i_branch_unit (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_flag_we    (flag_we),
        .i_next_flags (next_flags),
        .i_jmp_cond   (i_jmp_cond),
        .o_taken      (taken)
    );

endmodule

//--- hw/tl45_pkg.sv
package tl45_pkg;

    parameter int DATA_W = 32;  // Machine word
    parameter int REG_W  = 4;   // Register index bits

    // Unlisted opcode values decode as NOP
    typedef enum logic [4:0] {
        OP_NOP  = 5'h00,
        OP_ADD  = 5'h01,
        OP_SUB  = 5'h02,
        OP_MUL  = 5'h03,
        OP_SHRA = 5'h05,
        OP_OR   = 5'h06,
        OP_XOR  = 5'h07,
        OP_AND  = 5'h08,
        OP_NOT  = 5'h09,
        OP_SHL  = 5'h0A,
        OP_SHR  = 5'h0B,
        OP_BR   = 5'h0C,
        OP_CALL = 5'h0D,
        OP_RET  = 5'h0E
    } opcode_e;

    // Jump conditions, x86 style
    typedef enum logic [3:0] {
        JO      = 4'd0,
        JNO     = 4'd1,
        JS      = 4'd2,
        JNS     = 4'd3,
        JE      = 4'd4,
        JNE     = 4'd5,
        JB      = 4'd6,
        JNB     = 4'd7,
        JBE     = 4'd8,
        JA      = 4'd9,
        JL      = 4'd10,
        JGE     = 4'd11,
        JLE     = 4'd12,
        JG      = 4'd13,
        JMP     = 4'd14,
        JMP_ALT = 4'd15  // Also unconditional
    } cond_e;

    typedef enum logic {
        MUL_IDLE = 1'b0,
        MUL_WAIT = 1'b1
    } mul_state_e;

    typedef struct packed {
        logic overflow;
        logic zero;
        logic carry;
        logic sign;
    } flags_t;

endpackage

//--- hw/tl45_regfile.sv
`timescale 1ns/1ps

module tl45_regfile #(
    parameter int NUM_REGS = 16
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic [tl45_pkg::REG_W-1:0]  i_rd_a,
    input  logic [tl45_pkg::REG_W-1:0]  i_rd_b,
    output logic [tl45_pkg::DATA_W-1:0] o_rd_a_val,
    output logic [tl45_pkg::DATA_W-1:0] o_rd_b_val,
    input  logic                        i_wr_en,
    input  logic [tl45_pkg::REG_W-1:0]  i_wr_reg,
    input  logic [tl45_pkg::DATA_W-1:0] i_wr_val
);
    import tl45_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              wr_hit;      // Write lands in a real register
    logic [REG_W-1:0]  rd_idx [2];
    logic [DATA_W-1:0] rd_val [2];

    // r0 is never written, so it keeps its reset value of zero
    assign wr_hit = i_wr_en && (i_wr_reg != '0) && (int'(i_wr_reg) < NUM_REGS);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[i_wr_reg] <= i_wr_val;
        end
    end

    assign rd_idx[0] = i_rd_a;
    assign rd_idx[1] = i_rd_b;

    // Both read ports share the same bypass logic
    for (genvar p = 0; p < 2; p++) begin : g_rd
        logic unmapped;  // r0 or beyond NUM_REGS

        assign unmapped  = (rd_idx[p] == '0) || (int'(rd_idx[p]) >= NUM_REGS);
        assign rd_val[p] = unmapped                          ? '0 :
                           (wr_hit && i_wr_reg == rd_idx[p]) ? i_wr_val :  // Pending writeback
                                                               regs[rd_idx[p]];
    end

    assign o_rd_a_val = rd_val[0];
    assign o_rd_b_val = rd_val[1];

endmodule

//--- src.f
hw/tl45_pkg.sv
hw/tl45_regfile.sv
hw/tl45_branch_unit.sv
hw/tl45_alu.sv
hw/tl45_exec_top.sv
dv/tb_clkgen.sv
dv/tb_exec_assert.sv
dv/tb_checker.sv
dv/tb_top.sv
